/* rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

`default_nettype none

// Data path width of the integer slice.
`define XLEN 32

`define REG_ADDR_W 5

// Architectural registers, x0 included.
`define NUM_REGS 32

`default_nettype wire

`endif

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

    // Major opcodes handled by this slice, instr[6:0].
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000, // OP-IMM has only the ADDI form.
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_SLTU    = 3'b011,
        F3_XOR     = 3'b100,
        F3_SRL_SRA = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000; // Selects SUB and SRA.

endpackage

`default_nettype wire

/* rv_uop_pkg.sv */
`default_nettype none

package rv_uop_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B // Operand B goes straight to the result, used by LUI.
    } alu_op_e;

    typedef enum logic {
        OP_B_REG,
        OP_B_IMM
    } op_b_sel_e;

endpackage

`default_nettype wire

/* instr_decoder.sv */
`timescale 1ns/100ps
`include "rv_defs.svh"
`default_nettype none

module instr_decoder (
    input  wire [`XLEN-1:0]       instr,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`REG_ADDR_W-1:0] rd,
    output logic                  rs1_used,
    output logic                  rs2_used,
    output logic                  illegal,
    output logic [`XLEN-1:0]       imm,
    output rv_uop_pkg::alu_op_e   alu_op,
    output rv_uop_pkg::op_b_sel_e op_b_sel
);

    import rv_isa_pkg::*;
    import rv_uop_pkg::*;

    opcode_e          opcode;
    funct3_e          funct3;
    logic [6:0]       funct7;
    logic             funct7_alt;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;

    function automatic alu_op_e map_op(input funct3_e f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode     = opcode_e'(instr[6:0]);
    assign funct3     = funct3_e'(instr[14:12]);
    assign funct7     = instr[31:25];
    assign funct7_alt = (funct7 == FUNCT7_ALT);
    assign rd         = instr[11:7];
    assign rs1        = instr[19:15];
    assign rs2        = instr[24:20];
    assign imm_i      = {{(`XLEN-12){instr[31]}}, instr[31:20]};
    assign imm_u      = {instr[31:12], 12'b0};

    always_comb begin
        alu_op   = ALU_ADD;
        op_b_sel = OP_B_REG;
        imm      = imm_i;
        rs1_used = 1'b0;
        rs2_used = 1'b0;
        illegal  = 1'b0;
        case (opcode)
            OPC_OP: begin
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                alu_op   = map_op(funct3, funct7_alt);
                // Only ADD and SRL have an alternate encoding.
                if (funct7_alt) begin
                    illegal = (funct3 != F3_ADD_SUB) && (funct3 != F3_SRL_SRA);
                end else begin
                    illegal = (funct7 != FUNCT7_BASE);
                end
            end
            OPC_OP_IMM: begin
                rs1_used = 1'b1;
                op_b_sel = OP_B_IMM;
                alu_op   = map_op(funct3, funct7_alt && (funct3 == F3_SRL_SRA));
                if (funct3 == F3_SLL) begin
                    illegal = (funct7 != FUNCT7_BASE); // Upper bits hold funct7 for shifts.
                end else if (funct3 == F3_SRL_SRA) begin
                    illegal = (funct7 != FUNCT7_BASE) && !funct7_alt;
                end
            end
            OPC_LUI: begin
                op_b_sel = OP_B_IMM;
                imm      = imm_u;
                alu_op   = ALU_PASS_B;
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* register_file.sv */
`timescale 1ns/100ps
`include "rv_defs.svh"
`default_nettype none

module register_file (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire [`REG_ADDR_W-1:0] rs1,
    input  wire [`REG_ADDR_W-1:0] rs2,
    input  wire                   rs1_used,
    input  wire                   rs2_used,
    input  wire                   wr_en,
    input  wire [`REG_ADDR_W-1:0] wr_addr,
    input  wire [`XLEN-1:0]       wr_data,
    output logic [`XLEN-1:0]      rs1_value,
    output logic [`XLEN-1:0]      rs2_value
);

    logic [`XLEN-1:0] regs [`NUM_REGS];
    logic             wr_live;

    // Reads one port, taking the write data when it targets the same register.
    function automatic logic [`XLEN-1:0] read_port(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic                   used
    );
        logic [`XLEN-1:0] value;
        if (!used) begin
            value = '0;
        end else if (wr_live && (addr == wr_addr)) begin
            value = wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    assign wr_live = wr_en && (wr_addr != '0); // x0 never forwards.

    always_comb begin
        rs1_value = read_port(rs1, rs1_used);
        rs2_value = read_port(rs2, rs2_used);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

/* exec_stage.sv */
`timescale 1ns/100ps
`include "rv_defs.svh"
`default_nettype none

module exec_stage (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       in_valid,
    input  wire                       in_illegal,
    input  wire [`REG_ADDR_W-1:0]     in_rs1,
    input  wire [`REG_ADDR_W-1:0]     in_rs2,
    input  wire [`REG_ADDR_W-1:0]     in_rd,
    input  wire [`XLEN-1:0]           in_rs1_value,
    input  wire [`XLEN-1:0]           in_rs2_value,
    input  wire [`XLEN-1:0]           in_imm,
    input  wire rv_uop_pkg::alu_op_e  in_alu_op,
    input  wire rv_uop_pkg::op_b_sel_e in_op_b_sel,
    input  wire                       wb_valid,
    input  wire [`REG_ADDR_W-1:0]     wb_rd,
    input  wire [`XLEN-1:0]           wb_value,
    output logic                      out_valid,
    output logic                      out_illegal,
    output logic [`REG_ADDR_W-1:0]    out_rd,
    output logic [`XLEN-1:0]          out_value
);

    import rv_uop_pkg::*;

    logic [`REG_ADDR_W-1:0] ex_rs1;
    logic [`REG_ADDR_W-1:0] ex_rs2;
    logic [`XLEN-1:0]       ex_rs1_value;
    logic [`XLEN-1:0]       ex_rs2_value;
    logic [`XLEN-1:0]       ex_imm;
    alu_op_e                ex_alu_op;
    op_b_sel_e              ex_op_b_sel;
    logic [`XLEN-1:0]       op_a;
    logic [`XLEN-1:0]       op_b;
    logic [4:0]             shamt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            out_illegal <= 1'b0;
        end else begin
            out_valid   <= in_valid;
            out_illegal <= in_valid && in_illegal;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs1       <= in_rs1;
        ex_rs2       <= in_rs2;
        out_rd       <= in_rd;
        ex_rs1_value <= in_rs1_value;
        ex_rs2_value <= in_rs2_value;
        ex_imm       <= in_imm;
        ex_alu_op    <= in_alu_op;
        ex_op_b_sel  <= in_op_b_sel;
    end

    // The previous instruction is still in writeback and not yet in the file.
    assign op_a  = (wb_valid && (wb_rd == ex_rs1)) ? wb_value : ex_rs1_value;
    assign op_b  = (ex_op_b_sel == OP_B_IMM) ? ex_imm :
                   (wb_valid && (wb_rd == ex_rs2)) ? wb_value : ex_rs2_value;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:    out_value = op_a + op_b;
            ALU_SUB:    out_value = op_a - op_b;
            ALU_SLL:    out_value = op_a << shamt;
            ALU_SLT:    out_value = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   out_value = {{(`XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    out_value = op_a ^ op_b;
            ALU_SRL:    out_value = op_a >> shamt;
            ALU_SRA:    out_value = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     out_value = op_a | op_b;
            ALU_AND:    out_value = op_a & op_b;
            ALU_PASS_B: out_value = op_b;
            default:    out_value = '0;
        endcase
    end

endmodule

`default_nettype wire

/* writeback_stage.sv */
`timescale 1ns/100ps
`include "rv_defs.svh"
`default_nettype none

module writeback_stage (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    in_valid,
    input  wire                    in_illegal,
    input  wire [`REG_ADDR_W-1:0]  in_rd,
    input  wire [`XLEN-1:0]        in_value,
    output logic                   wr_en,
    output logic [`REG_ADDR_W-1:0] wr_addr,
    output logic [`XLEN-1:0]       wr_data,
    output logic                   result_valid,
    output logic [`REG_ADDR_W-1:0] result_rd,
    output logic [`XLEN-1:0]       result_value,
    output logic                   result_illegal
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result_valid   <= 1'b0;
            result_illegal <= 1'b0;
        end else begin
            result_valid   <= in_valid;
            result_illegal <= in_valid && in_illegal;
        end
    end

    always_ff @(posedge clk) begin
        result_rd    <= in_rd;
        result_value <= in_illegal ? '0 : in_value; // Illegal results carry no value.
    end

    // Also the bypass valid for the exec stage.
    assign wr_en   = result_valid && !result_illegal && (result_rd != '0);
    assign wr_addr = result_rd;
    assign wr_data = result_value;

endmodule

`default_nettype wire

/* int_exec_top.sv */
`timescale 1ns/100ps
`include "rv_defs.svh"
`default_nettype none

module int_exec_top (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    instr_valid,
    input  wire [`XLEN-1:0]        instr,
    output logic                   result_valid,
    output logic [`REG_ADDR_W-1:0] result_rd,
    output logic [`XLEN-1:0]       result_value,
    output logic                   result_illegal
);

    import rv_uop_pkg::*;

    logic [`REG_ADDR_W-1:0] dec_rs1;
    logic [`REG_ADDR_W-1:0] dec_rs2;
    logic [`REG_ADDR_W-1:0] dec_rd;
    logic                   dec_rs1_used;
    logic                   dec_rs2_used;
    logic                   dec_illegal;
    logic [`XLEN-1:0]       dec_imm;
    alu_op_e                dec_alu_op;
    op_b_sel_e              dec_op_b_sel;
    logic [`XLEN-1:0]       rs1_value;
    logic [`XLEN-1:0]       rs2_value;
    logic                   ex_valid;
    logic                   ex_illegal;
    logic [`REG_ADDR_W-1:0] ex_rd;
    logic [`XLEN-1:0]       ex_value;
    logic                   wr_en;
    logic [`REG_ADDR_W-1:0] wr_addr;
    logic [`XLEN-1:0]       wr_data;

    instr_decoder u_decoder (
        .instr    (instr),
        .rs1      (dec_rs1),
        .rs2      (dec_rs2),
        .rd       (dec_rd),
        .rs1_used (dec_rs1_used),
        .rs2_used (dec_rs2_used),
        .illegal  (dec_illegal),
        .imm      (dec_imm),
        .alu_op   (dec_alu_op),
        .op_b_sel (dec_op_b_sel)
    );

    register_file u_regfile (
        .clk       (clk),
        .rst_n     (rst_n),
        .rs1       (dec_rs1),
        .rs2       (dec_rs2),
        .rs1_used  (dec_rs1_used),
        .rs2_used  (dec_rs2_used),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value)
    );

    exec_stage u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (instr_valid),
        .in_illegal   (dec_illegal),
        .in_rs1       (dec_rs1),
        .in_rs2       (dec_rs2),
        .in_rd        (dec_rd),
        .in_rs1_value (rs1_value),
        .in_rs2_value (rs2_value),
        .in_imm       (dec_imm),
        .in_alu_op    (dec_alu_op),
        .in_op_b_sel  (dec_op_b_sel),
        .wb_valid     (wr_en),
        .wb_rd        (wr_addr),
        .wb_value     (wr_data),
        .out_valid    (ex_valid),
        .out_illegal  (ex_illegal),
        .out_rd       (ex_rd),
        .out_value    (ex_value)
    );

    writeback_stage u_writeback (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (ex_valid),
        .in_illegal     (ex_illegal),
        .in_rd          (ex_rd),
        .in_value       (ex_value),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .result_valid   (result_valid),
        .result_rd      (result_rd),
        .result_value   (result_value),
        .result_illegal (result_illegal)
    );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

/* int_exec_asserts.sv */
`timescale 1ns/100ps
`include "rv_defs.svh"
`default_nettype none

module int_exec_asserts (
    input wire             clk,
    input wire             rst_n,
    input wire             instr_valid,
    input wire             result_valid,
    input wire             result_illegal,
    input wire [`XLEN-1:0] result_value
);

    // Fixed two-edge latency from instruction to result.
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        result_valid == $past(instr_valid, 2))
        else $error("result_valid does not follow instr_valid by two cycles");

    a_illegal_valid: assert property (@(posedge clk) disable iff (!rst_n)
        result_illegal |-> result_valid)
        else $error("result_illegal high without result_valid");

    a_illegal_zero: assert property (@(posedge clk) disable iff (!rst_n)
        result_illegal |-> (result_value == '0))
        else $error("illegal result carries a nonzero value");

endmodule

bind int_exec_top int_exec_asserts u_asserts (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid    (instr_valid),
    .result_valid   (result_valid),
    .result_illegal (result_illegal),
    .result_value   (result_value)
);

`default_nettype wire

/* int_exec_tb.sv */
`timescale 1ns/100ps
`include "rv_defs.svh"
`default_nettype none

module int_exec_tb;

    import rv_isa_pkg::*;

    localparam int MAX_ROWS = 256;
    localparam int WAIT_LIMIT = 8;

    logic                   clk;
    logic                   rst_n;
    logic                   instr_valid;
    logic [`XLEN-1:0]       instr;
    logic                   result_valid;
    logic [`REG_ADDR_W-1:0] result_rd;
    logic [`XLEN-1:0]       result_value;
    logic                   result_illegal;

    logic                   row_valid [MAX_ROWS];
    logic [`XLEN-1:0]       row_instr [MAX_ROWS];
    logic [`REG_ADDR_W-1:0] row_rd [MAX_ROWS];
    logic [`XLEN-1:0]       row_value [MAX_ROWS];
    logic                   row_illegal [MAX_ROWS];
    int                     issue_cycle [MAX_ROWS];
    logic [`XLEN-1:0]       ref_regs [`NUM_REGS];
    int                     row_count = 0;
    int                     cycle = 0;
    int                     errors = 0;
    int                     passed = 0;
    bit                     timed_out = 0;

    tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

    int_exec_top UUT (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .result_valid(result_valid), .result_rd(result_rd),
        .result_value(result_value), .result_illegal(result_illegal)
    );

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input funct3_e f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input funct3_e f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic logic [4:0] rand_reg();
        return 5'(1 + ($urandom % 31)); // Never x0.
    endfunction

    // Reference model: computes the expected result and updates ref_regs.
    task automatic add_row(input logic [31:0] word);
        logic [6:0]        opc;
        logic [2:0]        f3;
        logic [6:0]        f7;
        logic              alt;
        logic [31:0]       a;
        logic signed [31:0] sa;
        logic [31:0]       b;
        logic [31:0]       val;
        logic              ill;
        opc = word[6:0];
        f3  = word[14:12];
        f7  = word[31:25];
        alt = (f7 == FUNCT7_ALT);
        a   = ref_regs[word[19:15]];
        sa  = a;
        b   = (opc == OPC_OP) ? ref_regs[word[24:20]] : {{20{word[31]}}, word[31:20]};
        val = '0;
        ill = 1'b0;
        if (opc == OPC_LUI) begin
            val = {word[31:12], 12'h000};
        end else if (opc == OPC_OP || opc == OPC_OP_IMM) begin
            case (f3)
                3'd0: val = (opc == OPC_OP && alt) ? a - b : a + b;
                3'd1: val = a << b[4:0];
                3'd2: val = (sa < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: val = (a < b) ? 32'd1 : 32'd0;
                3'd4: val = a ^ b;
                3'd5: val = alt ? 32'(sa >>> b[4:0]) : a >> b[4:0];
                3'd6: val = a | b;
                default: val = a & b;
            endcase
            if (opc == OPC_OP) begin
                ill = !(f7 == 7'd0 || (alt && (f3 == 3'd0 || f3 == 3'd5)));
            end else if (f3 == 3'd1) begin
                ill = (f7 != 7'd0);
            end else if (f3 == 3'd5) begin
                ill = !(f7 == 7'd0 || alt);
            end
        end else begin
            ill = 1'b1;
        end
        if (ill) val = '0;
        if (!ill && word[11:7] != 5'd0) ref_regs[word[11:7]] = val;
        row_valid[row_count]   = 1'b1;
        row_instr[row_count]   = word;
        row_rd[row_count]      = word[11:7];
        row_value[row_count]   = val;
        row_illegal[row_count] = ill;
        row_count++;
    endtask

    task automatic add_idle();
        row_valid[row_count] = 1'b0;
        row_instr[row_count] = '0;
        row_count++;
    endtask

    task automatic build_table();
        logic [6:0]  f7;
        logic [11:0] imm;
        for (int r = 0; r < `NUM_REGS; r++) ref_regs[r] = '0;
        add_row(enc_r(7'd0, 5'd0, 5'd0, F3_ADD_SUB, 5'd5));
        add_row(enc_r(7'd0, 5'd7, 5'd0, F3_OR, 5'd6));
        repeat (3) add_idle();
        add_row(enc_r(7'd0, 5'd0, 5'd0, F3_ADD_SUB, 5'd5));
        for (int r = 1; r < `NUM_REGS; r++) begin
            add_row({20'($urandom), 5'(r), OPC_LUI});
            add_row(enc_i(12'($urandom), 5'(r), F3_ADD_SUB, 5'(r)));
        end
        for (int round = 0; round < 4; round++) begin
            for (int k = 0; k < 8; k++) begin
                f7 = ((k == 0 || k == 5) && $urandom % 2) ? FUNCT7_ALT : 7'd0;
                add_row(enc_r(f7, rand_reg(), rand_reg(), funct3_e'(k), rand_reg()));
                imm = 12'($urandom);
                if (k == 1) imm[11:5] = 7'd0;
                if (k == 5) imm[11:5] = ($urandom % 2) ? FUNCT7_ALT : 7'd0;
                add_row(enc_i(imm, rand_reg(), funct3_e'(k), rand_reg()));
            end
        end
        // Distances 1, 2 and 3 on x20.
        add_row(enc_i(12'h7ff, 5'd21, F3_ADD_SUB, 5'd20));
        add_row(enc_r(7'd0, 5'd20, 5'd20, F3_ADD_SUB, 5'd22));
        add_row(enc_r(7'd0, 5'd22, 5'd20, F3_XOR, 5'd23));
        add_row(enc_r(FUNCT7_ALT, 5'd23, 5'd20, F3_ADD_SUB, 5'd24));
        add_row(enc_i(12'h123, 5'd1, F3_ADD_SUB, 5'd0));
        add_row(enc_r(7'd0, 5'd1, 5'd0, F3_ADD_SUB, 5'd25));
        add_row(enc_r(7'd0, 5'd0, 5'd0, F3_OR, 5'd25));
        add_row({25'h1abcd, 7'b0000011}); // Load opcode, not supported.
        add_row(enc_r(7'b0000001, 5'd3, 5'd4, F3_ADD_SUB, 5'd2));
        add_row(enc_i({FUNCT7_ALT, 5'd3}, 5'd4, F3_SLL, 5'd2));
        add_row(enc_r(7'd0, 5'd0, 5'd2, F3_ADD_SUB, 5'd26));
        add_row(enc_r(7'd0, 5'd0, 5'd1, F3_OR, 5'd27));
    endtask

    task automatic drive_rows();
        for (int i = 0; i < row_count; i++) begin
            @(posedge clk);
            instr_valid    <= row_valid[i];
            instr          <= row_instr[i];
            issue_cycle[i] = cycle + 1; // Visible to the DUT after this edge.
        end
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    task automatic check_rows();
        int waited;
        int bad;
        for (int i = 0; i < row_count && !timed_out; i++) begin
            if (!row_valid[i]) continue;
            waited = 0;
            bad = 0;
            while (!timed_out) begin
                @(negedge clk);
                if (result_valid) break;
                waited++;
                if (waited > WAIT_LIMIT) timed_out = 1;
            end
            if (timed_out) begin
                $display("timeout waiting for the result of row %0d", i);
                break;
            end
            if (cycle - issue_cycle[i] != 2) begin
                $display("row %0d result came %0d cycles after its instruction", i,
                         cycle - issue_cycle[i]);
                bad++;
            end
            if (result_rd != row_rd[i]) begin
                $display("error: result_rd got %h expected %h", result_rd, row_rd[i]);
                bad++;
            end
            if (result_value != row_value[i]) begin
                $display("error: result_value got %h expected %h", result_value, row_value[i]);
                bad++;
            end
            if (result_illegal != row_illegal[i]) begin
                $display("error: result_illegal got %h expected %h", result_illegal,
                         row_illegal[i]);
                bad++;
            end
            if (bad == 0) passed++;
            else errors++;
            $display("row %0d instr %h: %s", i, row_instr[i], bad == 0 ? "ok" : "mismatch");
        end
    endtask

    initial begin
        int waited;
        instr_valid = 1'b0;
        instr       = '0;
        void'($urandom(32'h633c_e7c0));
        build_table();
        waited = 0;
        while (rst_n !== 1'b1 && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > 10) timed_out = 1;
        end
        if (timed_out) $display("reset never released");
        if (!timed_out) begin
            fork
                drive_rows();
                check_rows();
            join
        end
        for (int n = 0; n < 4 && !timed_out; n++) begin
            @(negedge clk);
            if (result_valid) begin
                $display("result_valid high after the last instruction");
                errors++;
            end
        end
        $display("checked %0d results, %0d passed, %0d failed", passed + errors, passed,
                 errors);
        if (errors == 0 && !timed_out) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
rv_isa_pkg.sv
rv_uop_pkg.sv
instr_decoder.sv
register_file.sv
exec_stage.sv
writeback_stage.sv
int_exec_top.sv
tb_clk_gen.sv
int_exec_asserts.sv
int_exec_tb.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := int_exec_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)_sim
	./$(OBJ_DIR)/$(TOP)_sim | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
